// File: axi_tcdm_subsys.f
+incdir+logic
logic/axi_pkg.sv
logic/tcdm_pkg.sv
logic/tcdm_if.sv
logic/axi2tcdm.sv
logic/tcdm_sram_bank.sv
logic/axi_tcdm_subsys.sv
testbench/axi_tcdm_subsys_tb.sv

// File: logic/axi2tcdm.sv
/*
  Bridge from a single-beat AXI slave port to per-lane TCDM requests.
  A 64-bit beat is split into 32-bit lanes, one per bank, and the AXI
  write or read response is returned once every lane in use has answered.
  Addresses past the end of the memory get SLVERR without a bank access.
  Only one transaction is in flight at a time.
*/
`timescale 1ns/1ps
`include "axi_tcdm_defs.svh"

module axi2tcdm import axi_pkg::*, tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // write address channel
  input  logic      aw_valid_i,
  input  axi_addr_t aw_addr_i,
  input  axi_id_t   aw_id_i,
  output logic      aw_ready_o,
  // write data channel
  input  logic      w_valid_i,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  input  logic      w_last_i,
  output logic      w_ready_o,
  // write response channel
  output logic      b_valid_o,
  output axi_resp_t b_resp_o,
  output axi_id_t   b_id_o,
  input  logic      b_ready_i,
  // read address channel
  input  logic      ar_valid_i,
  input  axi_addr_t ar_addr_i,
  input  axi_id_t   ar_id_i,
  output logic      ar_ready_o,
  // read data channel
  output logic      r_valid_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  output axi_id_t   r_id_o,
  output logic      r_last_o,
  input  logic      r_ready_i,
  // one TCDM port per bank
  tcdm_if.master    tcdm_master_o [`NB_TCDM_PORTS],
  output logic      busy_o
);

  localparam int unsigned NB_LANES  = `NB_TCDM_PORTS;
  localparam int unsigned LANE_W    = $bits(tcdm_data_t);
  localparam int unsigned LANE_BE   = $bits(tcdm_be_t);
  localparam int unsigned ROW_W     = $bits(tcdm_addr_t);
  localparam int unsigned ROW_LSB   = $clog2(`AXI_DATA_WIDTH / 8);
  localparam int unsigned MEM_BYTES = NB_LANES * `BANK_WORDS * LANE_BE;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e state_q;
  state_e state_d;

  // lanes still to be issued, and lanes waiting for their r_valid
  logic [NB_LANES-1:0] todo_q;
  logic [NB_LANES-1:0] todo_d;
  logic [NB_LANES-1:0] pend_q;
  logic [NB_LANES-1:0] pend_d;

  logic [NB_LANES-1:0] lane_req;
  logic [NB_LANES-1:0] lane_gnt;
  logic [NB_LANES-1:0] lane_accept;
  logic [NB_LANES-1:0] lane_rvalid;
  logic [NB_LANES-1:0] wr_lanes;
  tcdm_data_t          lane_rdata [NB_LANES];

  logic write_pending;
  logic aw_hs;
  logic ar_hs;
  logic wr_err;
  logic rd_err;
  logic lanes_done;

  axi_id_t    id_q;
  tcdm_addr_t row_q;
  axi_data_t  wdata_q;
  axi_strb_t  strb_q;
  axi_resp_t  resp_q;
  axi_data_t  rdata_q;
  logic       is_write_q;

  // a write needs both AW and W present and wins over a read in the same cycle
  assign write_pending = aw_valid_i & w_valid_i;
  assign aw_ready_o    = (state_q == ST_IDLE) & write_pending;
  assign w_ready_o     = aw_ready_o;
  assign ar_ready_o    = (state_q == ST_IDLE) & ar_valid_i & ~write_pending;
  assign aw_hs         = aw_valid_i & aw_ready_o;
  assign ar_hs         = ar_valid_i & ar_ready_o;

  // bursts are not supported, so a beat without w_last is refused as well
  assign wr_err = (aw_addr_i >= axi_addr_t'(MEM_BYTES)) | ~w_last_i;
  assign rd_err = ar_addr_i >= axi_addr_t'(MEM_BYTES);

  // a write lane with no enabled byte is skipped entirely
  always_comb begin
    for (int i = 0; i < NB_LANES; i++) begin
      wr_lanes[i] = |w_strb_i[LANE_BE*i +: LANE_BE];
    end
  end

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    assign tcdm_master_o[i].req   = lane_req[i];
    assign tcdm_master_o[i].add   = row_q;
    assign tcdm_master_o[i].wen   = ~is_write_q;
    assign tcdm_master_o[i].wdata = wdata_q[LANE_W*i +: LANE_W];
    assign tcdm_master_o[i].be    = is_write_q ? strb_q[LANE_BE*i +: LANE_BE] : '1;

    assign lane_gnt[i]    = tcdm_master_o[i].gnt;
    assign lane_rvalid[i] = tcdm_master_o[i].r_valid;
    assign lane_rdata[i]  = tcdm_master_o[i].r_rdata;
  end

  assign lane_req    = (state_q == ST_REQ) ? todo_q : '0;
  assign lane_accept = lane_req & lane_gnt;
  assign lanes_done  = (pend_q & ~lane_rvalid) == '0;

  always_comb begin
    state_d = state_q;
    todo_d  = todo_q & ~lane_accept;
    pend_d  = (pend_q & ~lane_rvalid) | lane_accept;

    case (state_q)
      ST_IDLE: begin
        if (aw_hs) begin
          state_d = wr_err ? ST_RESP : ST_REQ;
          todo_d  = wr_err ? '0 : wr_lanes;
        end else if (ar_hs) begin
          // a read always fetches the whole beat from both banks
          state_d = rd_err ? ST_RESP : ST_REQ;
          todo_d  = rd_err ? '0 : '1;
        end
      end
      ST_REQ: begin
        if ((todo_q & ~lane_gnt) == '0) begin
          state_d = is_write_q ? ST_RESP : ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (lanes_done) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        if ((b_valid_o & b_ready_i) | (r_valid_o & r_ready_i)) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      todo_q  <= '0;
      pend_q  <= '0;
    end else begin
      state_q <= state_d;
      todo_q  <= todo_d;
      pend_q  <= pend_d;
    end
  end

  // transaction payload, captured on the address handshake
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q       <= aw_id_i;
      row_q      <= aw_addr_i[ROW_LSB +: ROW_W];
      wdata_q    <= w_data_i;
      strb_q     <= w_strb_i;
      resp_q     <= wr_err ? RESP_SLVERR : RESP_OKAY;
      is_write_q <= 1'b1;
    end else if (ar_hs) begin
      id_q       <= ar_id_i;
      row_q      <= ar_addr_i[ROW_LSB +: ROW_W];
      resp_q     <= rd_err ? RESP_SLVERR : RESP_OKAY;
      is_write_q <= 1'b0;
      // stays zero for a refused read
      rdata_q    <= '0;
    end

    for (int i = 0; i < NB_LANES; i++) begin
      if (!is_write_q && pend_q[i] && lane_rvalid[i]) begin
        rdata_q[LANE_W*i +: LANE_W] <= lane_rdata[i];
      end
    end
  end

  // the write response may rise in the same cycle as the last lane r_valid
  assign b_valid_o = (state_q == ST_RESP) & is_write_q & lanes_done;
  assign b_resp_o  = resp_q;
  assign b_id_o    = id_q;

  assign r_valid_o = (state_q == ST_RESP) & ~is_write_q & lanes_done;
  assign r_data_o  = rdata_q;
  assign r_resp_o  = resp_q;
  assign r_id_o    = id_q;
  assign r_last_o  = r_valid_o;

  assign busy_o = (state_q != ST_IDLE);

endmodule

// File: logic/axi_pkg.sv
/*
  AXI field types and response codes for the single-beat slave port.
  Shared by the bridge, the subsystem top level and the testbench.
*/
`include "axi_tcdm_defs.svh"

package axi_pkg;

  // only the two codes this slave ever returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  typedef logic [`AXI_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]   axi_data_t;

  // one strobe bit per byte of the beat
  typedef logic [`AXI_DATA_WIDTH/8-1:0] axi_strb_t;

  typedef logic [`AXI_ID_WIDTH-1:0]     axi_id_t;

endpackage

// File: logic/axi_tcdm_defs.svh
/*
  Width and size constants for the AXI slave port and the banked TCDM
  behind it. Included by the packages and by every module that sizes
  arrays or loops from these values.
*/
`ifndef AXI_TCDM_DEFS_SVH
`define AXI_TCDM_DEFS_SVH

// AXI side of the bridge
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH   4

// one 32-bit lane per bank, each lane takes half of a 64-bit beat
`define NB_TCDM_PORTS  2

// words per bank, two banks of 64 words cover 512 bytes
`define BANK_WORDS     64

`endif

// File: logic/axi_tcdm_subsys.sv
/*
  Top level of the AXI-to-TCDM subsystem. Exposes the single-beat AXI
  slave channels as plain ports and connects the bridge to one SRAM bank
  per lane through a TCDM interface.
*/
`timescale 1ns/1ps
`include "axi_tcdm_defs.svh"

module axi_tcdm_subsys import axi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      aw_valid_i,
  input  axi_addr_t aw_addr_i,
  input  axi_id_t   aw_id_i,
  output logic      aw_ready_o,
  input  logic      w_valid_i,
  input  axi_data_t w_data_i,
  input  axi_strb_t w_strb_i,
  input  logic      w_last_i,
  output logic      w_ready_o,
  output logic      b_valid_o,
  output axi_resp_t b_resp_o,
  output axi_id_t   b_id_o,
  input  logic      b_ready_i,
  input  logic      ar_valid_i,
  input  axi_addr_t ar_addr_i,
  input  axi_id_t   ar_id_i,
  output logic      ar_ready_o,
  output logic      r_valid_o,
  output axi_data_t r_data_o,
  output axi_resp_t r_resp_o,
  output axi_id_t   r_id_o,
  output logic      r_last_o,
  input  logic      r_ready_i,
  output logic      busy_o
);

  // one lane per bank
  tcdm_if tcdm_lane [`NB_TCDM_PORTS] ();

  axi2tcdm u_axi2tcdm (
    .clk_i         ( clk_i      ),
    .rst_n_i       ( rst_n_i    ),
    .aw_valid_i    ( aw_valid_i ),
    .aw_addr_i     ( aw_addr_i  ),
    .aw_id_i       ( aw_id_i    ),
    .aw_ready_o    ( aw_ready_o ),
    .w_valid_i     ( w_valid_i  ),
    .w_data_i      ( w_data_i   ),
    .w_strb_i      ( w_strb_i   ),
    .w_last_i      ( w_last_i   ),
    .w_ready_o     ( w_ready_o  ),
    .b_valid_o     ( b_valid_o  ),
    .b_resp_o      ( b_resp_o   ),
    .b_id_o        ( b_id_o     ),
    .b_ready_i     ( b_ready_i  ),
    .ar_valid_i    ( ar_valid_i ),
    .ar_addr_i     ( ar_addr_i  ),
    .ar_id_i       ( ar_id_i    ),
    .ar_ready_o    ( ar_ready_o ),
    .r_valid_o     ( r_valid_o  ),
    .r_data_o      ( r_data_o   ),
    .r_resp_o      ( r_resp_o   ),
    .r_id_o        ( r_id_o     ),
    .r_last_o      ( r_last_o   ),
    .r_ready_i     ( r_ready_i  ),
    .tcdm_master_o ( tcdm_lane  ),
    .busy_o        ( busy_o     )
  );

  for (genvar i = 0; i < `NB_TCDM_PORTS; i++) begin : gen_bank
    tcdm_sram_bank u_tcdm_sram_bank (
      .clk_i      ( clk_i        ),
      .rst_n_i    ( rst_n_i      ),
      .tcdm_slave ( tcdm_lane[i] )
    );
  end

endmodule

// File: logic/tcdm_if.sv
/*
  TCDM request/response channel for one bank lane. The bridge drives the
  request side through the master modport, the bank answers through the
  slave modport with a grant and a response one cycle later.
*/
`timescale 1ns/1ps

interface tcdm_if import tcdm_pkg::*; ();

  // request side
  logic       req;
  tcdm_addr_t add;
  logic       wen;
  tcdm_data_t wdata;
  tcdm_be_t   be;

  // grant and response side
  logic       gnt;
  logic       r_valid;
  tcdm_data_t r_rdata;

  modport master (
    output req, add, wen, wdata, be,
    input  gnt, r_valid, r_rdata
  );

  modport slave (
    input  req, add, wen, wdata, be,
    output gnt, r_valid, r_rdata
  );

endinterface

// File: logic/tcdm_pkg.sv
/*
  TCDM word, byte-enable and row types. Used by the bridge lanes, the
  SRAM banks and the request/response interface between them.
*/
`include "axi_tcdm_defs.svh"

package tcdm_pkg;

  typedef logic [31:0] tcdm_data_t;
  typedef logic [3:0]  tcdm_be_t;

  // row index inside one bank, not a byte address
  typedef logic [$clog2(`BANK_WORDS)-1:0] tcdm_addr_t;

endpackage

// File: logic/tcdm_sram_bank.sv
/*
  Single-port SRAM bank of 32-bit words with byte enables, behind a TCDM
  slave port. Every request is granted at once and r_valid follows one
  cycle later for reads and writes alike.
*/
`timescale 1ns/1ps
`include "axi_tcdm_defs.svh"

module tcdm_sram_bank import tcdm_pkg::*; (
  input logic   clk_i,
  input logic   rst_n_i,
  tcdm_if.slave tcdm_slave
);

  localparam int unsigned NB_BYTES = $bits(tcdm_be_t);

  tcdm_data_t mem_q [`BANK_WORDS];
  tcdm_data_t rdata_q;
  logic       r_valid_q;
  logic       accept;

  // a single master per bank, so there is nothing to arbitrate
  assign tcdm_slave.gnt     = 1'b1;
  assign accept             = tcdm_slave.req & tcdm_slave.gnt;
  assign tcdm_slave.r_valid = r_valid_q;
  assign tcdm_slave.r_rdata = rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= accept;
    end
  end

  // wen high is a read, otherwise only the enabled bytes are written
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (tcdm_slave.wen) begin
        rdata_q <= mem_q[tcdm_slave.add];
      end else begin
        for (int b = 0; b < NB_BYTES; b++) begin
          if (tcdm_slave.be[b]) begin
            mem_q[tcdm_slave.add][8*b +: 8] <= tcdm_slave.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it from the project root and
# passes only when the simulation prints the pass message
verilator --binary --timing -j 0 --top-module axi_tcdm_subsys_tb -f axi_tcdm_subsys.f \
  || { echo "Verilator build failed"; exit 1; }
output=$(./obj_dir/Vaxi_tcdm_subsys_tb 2>&1)
echo "$output"
echo "$output" | grep -qx "Test completed successfully" && exit 0 || exit 1

// File: testbench/axi_tcdm_subsys_tb.sv
/*
  Testbench for the AXI-to-TCDM subsystem. Replays the trace file one
  transaction at a time, stalls B and R with random ready values and
  checks response codes, IDs and read data against the trace. Every fully
  written in-range row is read back at the end against the trace writes.
*/
`timescale 1ns/1ps

module axi_tcdm_subsys_tb import axi_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 3;
  localparam int CYCLES_PER_TX = 40;

  // the memory covers 512 bytes, one 64-bit row per 8 bytes
  localparam int unsigned MEM_BYTES = 512;
  localparam int unsigned ROW_BYTES = 8;

  logic      clk_i;
  logic      rst_n_i;
  logic      aw_valid_i;
  axi_addr_t aw_addr_i;
  axi_id_t   aw_id_i;
  logic      aw_ready_o;
  logic      w_valid_i;
  axi_data_t w_data_i;
  axi_strb_t w_strb_i;
  logic      w_last_i;
  logic      w_ready_o;
  logic      b_valid_o;
  axi_resp_t b_resp_o;
  axi_id_t   b_id_o;
  logic      b_ready_i;
  logic      ar_valid_i;
  axi_addr_t ar_addr_i;
  axi_id_t   ar_id_i;
  logic      ar_ready_o;
  logic      r_valid_o;
  axi_data_t r_data_o;
  axi_resp_t r_resp_o;
  axi_id_t   r_id_o;
  logic      r_last_o;
  logic      r_ready_i;
  logic      busy_o;

  // one entry per trace line
  bit        tr_write [$];
  axi_id_t   tr_id [$];
  axi_addr_t tr_addr [$];
  axi_data_t tr_wdata [$];
  axi_strb_t tr_strb [$];
  axi_resp_t tr_resp [$];
  axi_data_t tr_rdata [$];

  // content that the in-range trace writes leave in each row, and the bytes written
  axi_data_t final_data [int unsigned];
  axi_strb_t final_seen [int unsigned];

  logic [31:0] rng_state = 32'd58121;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  axi_tcdm_subsys u_axi_tcdm_subsys (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // the limit stays zero until the trace length is known
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      stop_run($sformatf("simulation timed out after %0d cycles", cycle_count));
    end
  end

  task automatic stop_run(string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ready is high about three cycles out of four
  task automatic next_ready(output logic rdy);
    rng_state = xorshift32(rng_state);
    rdy = (rng_state[1:0] != 2'b00);
  endtask

  // a set strobe replaces its byte, a clear strobe keeps the old byte
  function automatic axi_data_t apply_strobes(axi_data_t old, axi_data_t wdata,
                                              axi_strb_t strb);
    axi_data_t merged;
    merged = old;
    for (int b = 0; b < $bits(axi_strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic check_resp(string what, axi_resp_t got, axi_resp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s is %s, expected %s",
                         $time, what, got.name(), exp.name()));
    end
  endtask

  task automatic check_data(string what, axi_data_t got, axi_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_id(string what, axi_id_t got, axi_id_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    int unsigned row;
    string       line;
    logic[3:0]   op;
    axi_id_t     id;
    axi_addr_t   addr;
    axi_data_t   wdata;
    axi_strb_t   strb;
    logic[1:0]   resp;
    axi_data_t   rdata;
    fd = $fopen("testbench/axi_tcdm_trace.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the trace file testbench/axi_tcdm_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h", op, id, addr, wdata, strb, resp, rdata);
      if (n != 7) begin
        stop_run({"malformed trace line: ", line});
      end
      tr_write.push_back(op == 4'h1);
      tr_id.push_back(id);
      tr_addr.push_back(addr);
      tr_wdata.push_back(wdata);
      tr_strb.push_back(strb);
      tr_resp.push_back(axi_resp_t'(resp));
      tr_rdata.push_back(rdata);
      // address bits 0 to 2 select no row, so every row is 8 bytes apart
      if (op == 4'h1 && addr < MEM_BYTES) begin
        row = addr / ROW_BYTES;
        if (!final_data.exists(row)) begin
          final_data[row] = '0;
          final_seen[row] = '0;
        end
        final_data[row] = apply_strobes(final_data[row], wdata, strb);
        final_seen[row] = final_seen[row] | strb;
      end
    end
    $fclose(fd);
    if (tr_write.size() == 0) begin
      stop_run("the trace file holds no transactions");
    end
  endtask

  // waits for the address handshake, ready is sampled mid-cycle
  task automatic wait_accept(input logic is_write);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = is_write ? (aw_ready_o & w_ready_o) : ar_ready_o;
      @(posedge clk_i);
      #1;
    end
    if (busy_o !== 1'b1) begin
      stop_run("busy_o is low right after an address handshake");
    end
  endtask

  task automatic collect_b(axi_resp_t exp_resp, axi_id_t exp_id);
    logic      done;
    logic      seen;
    logic      rdy;
    axi_resp_t held_resp;
    axi_id_t   held_id;
    done = 1'b0;
    seen = 1'b0;
    while (!done) begin
      next_ready(rdy);
      b_ready_i = rdy;
      @(negedge clk_i);
      if (b_valid_o) begin
        if (seen) begin
          check_resp("stalled b_resp", b_resp_o, held_resp);
          check_id("stalled b_id", b_id_o, held_id);
        end
        held_resp = b_resp_o;
        held_id   = b_id_o;
        seen      = 1'b1;
        done      = b_ready_i;
      end else if (seen) begin
        stop_run("b_valid dropped before the write response was accepted");
      end
      @(posedge clk_i);
      #1;
    end
    b_ready_i = 1'b0;
    check_resp("b_resp", held_resp, exp_resp);
    check_id("b_id", held_id, exp_id);
  endtask

  task automatic collect_r(axi_resp_t exp_resp, axi_id_t exp_id, axi_data_t exp_data);
    logic      done;
    logic      seen;
    logic      rdy;
    axi_resp_t held_resp;
    axi_id_t   held_id;
    axi_data_t held_data;
    done = 1'b0;
    seen = 1'b0;
    while (!done) begin
      next_ready(rdy);
      r_ready_i = rdy;
      @(negedge clk_i);
      if (r_valid_o) begin
        if (seen) begin
          check_resp("stalled r_resp", r_resp_o, held_resp);
          check_id("stalled r_id", r_id_o, held_id);
          check_data("stalled r_data", r_data_o, held_data);
        end
        if (r_last_o !== 1'b1) begin
          stop_run("r_last is low while r_valid is high");
        end
        held_resp = r_resp_o;
        held_id   = r_id_o;
        held_data = r_data_o;
        seen      = 1'b1;
        done      = r_ready_i;
      end else if (seen) begin
        stop_run("r_valid dropped before the read data was accepted");
      end
      @(posedge clk_i);
      #1;
    end
    r_ready_i = 1'b0;
    check_resp("r_resp", held_resp, exp_resp);
    check_id("r_id", held_id, exp_id);
    check_data("r_data", held_data, exp_data);
  endtask

  task automatic run_transaction(int idx);
    if (tr_write[idx]) begin
      aw_valid_i = 1'b1;
      aw_addr_i  = tr_addr[idx];
      aw_id_i    = tr_id[idx];
      w_valid_i  = 1'b1;
      w_data_i   = tr_wdata[idx];
      w_strb_i   = tr_strb[idx];
      w_last_i   = 1'b1;
      wait_accept(1'b1);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      collect_b(tr_resp[idx], tr_id[idx]);
    end else begin
      ar_valid_i = 1'b1;
      ar_addr_i  = tr_addr[idx];
      ar_id_i    = tr_id[idx];
      wait_accept(1'b0);
      ar_valid_i = 1'b0;
      collect_r(tr_resp[idx], tr_id[idx], tr_rdata[idx]);
    end
    // the response handshake edge has passed, so the bridge is idle again
    if (busy_o !== 1'b0) begin
      stop_run($sformatf("busy_o still high after the response of trace line %0d", idx));
    end
  endtask

  // a refused write that reached a bank through an aliased row shows up here
  task automatic read_back_rows();
    foreach (final_seen[row]) begin
      if (final_seen[row] == '1) begin
        ar_valid_i = 1'b1;
        ar_addr_i  = axi_addr_t'(row * ROW_BYTES);
        ar_id_i    = axi_id_t'(row);
        wait_accept(1'b0);
        ar_valid_i = 1'b0;
        collect_r(RESP_OKAY, axi_id_t'(row), final_data[row]);
      end
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    r_ready_i  = 1'b0;
    load_trace();
    cycle_limit = CYCLES_PER_TX * (tr_write.size() + final_seen.size()) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if ({aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o, busy_o} !== 6'b0) begin
      stop_run("a ready, valid or busy output is high after reset");
    end
    @(posedge clk_i);
    #1;
    foreach (tr_write[i]) begin
      run_transaction(i);
    end
    read_back_rows();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: testbench/axi_tcdm_trace.txt
# op(1=write 0=read) id addr wdata strb exp_resp(0=OKAY 2=SLVERR) exp_rdata, all hex
# exp_rdata is checked on reads only, wdata and strb on writes only
1 3 00000010 0123456789abcdef ff 0 0000000000000000
0 5 00000010 0000000000000000 00 0 0123456789abcdef
1 2 00000020 1111111122222222 ff 0 0000000000000000
1 6 00000020 aabbccddeeff0011 f0 0 0000000000000000
1 7 00000020 5566778899aabbcc 21 0 0000000000000000
0 8 00000020 0000000000000000 00 0 aabb77dd222222cc
1 9 00000028 fedcba9876543210 ff 0 0000000000000000
0 a 00000020 0000000000000000 00 0 aabb77dd222222cc
0 b 0000002d 0000000000000000 00 0 fedcba9876543210
1 c 000001f8 cafef00d0badbeef ff 0 0000000000000000
0 d 000001f8 0000000000000000 00 0 cafef00d0badbeef
1 e 00000010 ffffffffffffffff 00 0 0000000000000000
0 f 00000010 0000000000000000 00 0 0123456789abcdef
1 4 00000200 deadbeefdeadbeef ff 2 0000000000000000
0 1 00000200 0000000000000000 00 2 0000000000000000
0 0 fffffff8 0000000000000000 00 2 0000000000000000
1 5 00000210 0f0f0f0f0f0f0f0f ff 2 0000000000000000
0 6 00000020 0000000000000000 00 0 aabb77dd222222cc
0 7 000001f8 0000000000000000 00 0 cafef00d0badbeef
